/* project.f */
dbg_or1k_pkg.sv
dbg_or1k_status_reg.sv
dbg_or1k_crc32.sv
dbg_or1k_spr_biu.sv
dbg_or1k_datapath.sv
dbg_or1k_cmd_fsm.sv
dbg_or1k_module.sv
dbg_or1k_sva.sv
tb_dbg_or1k.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_dbg_or1k -f project.f \
  && ./obj_dir/Vtb_dbg_or1k | tee /dev/stderr | grep -x "test passed" > /dev/null \
  || { echo "simulation failed"; exit 1; }

/* tb_dbg_or1k.sv */
`timescale 1ns/1ps

module tb_dbg_or1k
  import dbg_or1k_pkg::*;
();

  localparam int WATCHDOG_CYCLES = (5 + 3 + 6 + 4) * 60 + 3000;  // Burst words times 60 plus margin

  logic            tck, rst, tdi, cap, sh, upd, sel, bp;
  logic [DR_W-1:0] dr;          // TAP data register model
  logic            tdo, inhibit, stall, cpurst;
  spr_req_t        cpu_req;
  logic [31:0]     cpu_rdata;
  logic            cpu_ack;
  logic            tdo_seen, inh_seen;  // Sampled once per cycle
  logic [1:0]      exp_status;
  logic [31:0]     addr_log[$];  // SPR accesses seen by the CPU model
  logic            we_log[$];
  logic [31:0]     wdata_log[$];
  int              errors, checks;

  dbg_or1k_module #(.CNT_W(16)) uut (
    .tck_i(tck), .rst_i(rst), .tdi_i(tdi), .capture_dr_i(cap), .shift_dr_i(sh),
    .update_dr_i(upd), .data_register_i(dr), .module_select_i(sel),
    .module_tdo_o(tdo), .top_inhibit_o(inhibit), .cpu_req_o(cpu_req),
    .cpu_rdata_i(cpu_rdata), .cpu_ack_i(cpu_ack), .cpu_bp_i(bp),
    .cpu_stall_o(stall), .cpu_rst_o(cpurst)
  );

  initial begin
    tck = 1'b0;
    forever #5 tck = ~tck;
  end

  ////////////////////
  // Reference models
  ////////////////////

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};  // Whole-address pattern
  endfunction

  function automatic logic [31:0] crc_next(input logic [31:0] c, input logic b);
    return (c >> 1) ^ ((c[0] ^ b) ? 32'hEDB8_8320 : 32'h0);  // Reflected, LSB first
  endfunction

  // CPU side answers after 0 to 20 cycles
  initial begin
    int unsigned delay;
    logic        busy;
    cpu_ack   = 1'b0;
    cpu_rdata = '0;
    busy      = 1'b0;
    delay     = 0;
    forever begin
      @(negedge tck);
      if (cpu_ack) begin
        cpu_ack = 1'b0;
      end else if (cpu_req.stb) begin
        if (!busy) begin
          busy  = 1'b1;
          delay = $urandom % 21;
          addr_log.push_back(cpu_req.addr);
          we_log.push_back(cpu_req.we);
          wdata_log.push_back(cpu_req.wdata);
        end
        if (delay == 0) begin
          cpu_ack   = 1'b1;
          cpu_rdata = mem_word(cpu_req.addr);
          busy      = 1'b0;
        end else begin
          delay = delay - 1;
        end
      end
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // One TAP cycle, outputs sampled after the inputs settle
  task automatic tap_cycle(input logic c, input logic s, input logic u, input logic t);
    @(negedge tck);
    // TDI enters at the MSB
    if (sh) dr = {tdi, dr[DR_W-1:1]};  // Shift of the cycle just ended
    cap = c;
    sh  = s;
    upd = u;
    tdi = t;
    #1;
    tdo_seen = tdo;
    inh_seen = inhibit;
  endtask

  task automatic send_cmd(input logic [DR_W-1:0] cmd);
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    for (int i = 0; i < DR_W; i++) tap_cycle(1'b0, 1'b1, 1'b0, cmd[i]);
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0);
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic write_status(input logic [1:0] val);
    send_cmd({1'b0, CMD_IREG_WR, INTREG_STATUS, val, 45'd0});
    exp_status = val;
    check(32'(stall), 32'(val[0]), "stall after write");
    check(32'(cpurst), 32'(val[1]), "cpu reset after write");
  endtask

  task automatic readback_status(input logic [1:0] exp);
    logic [1:0] got;
    got = '0;
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    for (int i = 0; i < DR_W; i++) begin  // Zeros so a later update does nothing
      tap_cycle(1'b0, 1'b1, 1'b0, 1'b0);
      if (i < 2) got[i] = tdo_seen;
    end
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    check(32'(got), 32'(exp), "status readback");
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic reset_test();
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    check(32'(stall), 32'd0, "stall after reset");
    check(32'(cpurst), 32'd0, "cpu reset after reset");
    check(32'(cpu_req.stb), 32'd0, "stb after reset");
    check(32'(inhibit), 32'd0, "top inhibit after reset");
    check(32'(tdo), 32'd0, "tdo after reset");
  endtask

  task automatic status_test();
    write_status(2'b11);
    readback_status(2'b11);
    write_status(2'b01);
    readback_status(2'b01);
  endtask

  task automatic bp_test();
    write_status(2'b00);
    @(negedge tck);
    bp = 1'b1;
    @(negedge tck);
    bp = 1'b0;
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    check(32'(stall), 32'd1, "stall after breakpoint");
    readback_status(2'b01);
    write_status(2'b00);
    readback_status(2'b00);
  endtask

  task automatic write_burst(input int n, input logic flip);
    logic [31:0] base, crc, sent;
    logic [31:0] words[0:15];
    int          first;
    base  = $urandom;
    first = addr_log.size();
    for (int k = 0; k < n; k++) words[k] = $urandom;
    send_cmd({1'b0, CMD_BWRITE32, base, 16'(n)});
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b1);         // Start bit
    crc = 32'hFFFF_FFFF;
    for (int k = 0; k < n; k++) begin
      for (int b = 0; b < 32; b++) begin
        tap_cycle(1'b0, 1'b1, 1'b0, words[k][b]);
        crc = crc_next(crc, words[k][b]);
      end
    end
    check(32'(inh_seen), 32'd1, "top inhibit in write burst");
    sent = flip ? crc ^ 32'd1 : crc;
    for (int b = 0; b < 32; b++) tap_cycle(1'b0, 1'b1, 1'b0, sent[b]);
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    check(32'(tdo_seen), 32'(!flip), "write CRC match bit");
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0);
    repeat (30) tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    check(32'(inh_seen), 32'd0, "top inhibit after write");
    check(32'(addr_log.size() - first), 32'(n), "write access count");
    for (int k = 0; k < n && first + k < addr_log.size(); k++) begin
      check(addr_log[first+k], base + 32'(k), "write address");
      check(32'(we_log[first+k]), 32'd1, "write enable");
      check(wdata_log[first+k], words[k], "write data");
    end
  endtask

  // A nonzero stop_bits ends the burst early with an update
  task automatic read_burst(input int n, input int stop_bits);
    logic [31:0] base, crc, got, exp_word;
    int          first, polls, bits;
    base  = $urandom;
    first = addr_log.size();
    bits  = 0;
    send_cmd({1'b0, CMD_BREAD32, base, 16'(n)});
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    polls = 0;
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b0);
    while (!tdo_seen && polls < 200) begin     // Poll for the ready bit
      polls++;
      tap_cycle(1'b0, 1'b1, 1'b0, 1'b0);
    end
    check(32'(tdo_seen), 32'd1, "read ready bit");
    check(32'(inh_seen), 32'd1, "top inhibit in read burst");
    crc = 32'hFFFF_FFFF;
    for (int k = 0; k < n && !(stop_bits > 0 && bits >= stop_bits); k++) begin
      got      = '0;
      exp_word = mem_word(base + 32'(k));
      for (int b = 0; b < 32 && !(stop_bits > 0 && bits >= stop_bits); b++) begin
        tap_cycle(1'b0, 1'b1, 1'b0, 1'b0);
        got[b] = tdo_seen;
        crc    = crc_next(crc, exp_word[b]);
        bits++;
        if (b == 31) check(got, exp_word, "read data word");
      end
    end
    if (stop_bits == 0) begin
      got = '0;
      for (int b = 0; b < 32; b++) begin
        tap_cycle(1'b0, 1'b1, 1'b0, 1'b0);
        got[b] = tdo_seen;
      end
      check(got, crc, "read CRC");
    end
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0);
    repeat (30) tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);  // Let an open access finish
    check(32'(inh_seen), 32'd0, "top inhibit after read");
    if (stop_bits == 0) begin
      check(32'(addr_log.size() - first), 32'(n), "read access count");
    end else begin
      check(32'(addr_log.size() - first), 32'd3, "read accesses before stop");
      readback_status(exp_status);
      repeat (40) tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
      check(32'(addr_log.size() - first), 32'd3, "no strobe after early update");
    end
    for (int k = 0; first + k < addr_log.size(); k++) begin
      check(addr_log[first+k], base + 32'(k), "read address");
      check(32'(we_log[first+k]), 32'd0, "read has we low");
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    void'($urandom(32'hf556_b9f2));
    errors     = 0;
    checks     = 0;
    rst        = 1'b1;
    dr         = '0;
    tdi        = 1'b0;
    cap        = 1'b0;
    sh         = 1'b0;
    upd        = 1'b0;
    sel        = 1'b1;    // This module stays selected
    bp         = 1'b0;
    exp_status = 2'b00;
    repeat (4) @(negedge tck);
    rst = 1'b0;
    reset_test();
    status_test();
    bp_test();
    write_burst(5, 1'b0);
    write_burst(3, 1'b1);   // Corrupted CRC
    read_burst(6, 0);
    read_burst(4, 40);      // Update inside the second word
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge tck);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

/* dbg_or1k_sva.sv */
`timescale 1ns/1ps

module dbg_or1k_sva
  import dbg_or1k_pkg::*;
(
  input logic     tck_i,
  input logic     rst_i,
  input spr_req_t cpu_req_o,
  input logic     cpu_ack_i
);

  ////////////////////
  // SPR bus handshake
  ////////////////////

  // Strobe and payload held until the CPU acknowledges
  a_stb_hold: assert property (@(posedge tck_i) disable iff (rst_i)
    cpu_req_o.stb && !cpu_ack_i |=> cpu_req_o.stb && $stable(cpu_req_o.addr)
      && $stable(cpu_req_o.wdata) && $stable(cpu_req_o.we))
    else $error("SPR request dropped or changed before ack");

  // No bus request while reset is applied
  a_stb_reset: assert property (@(posedge tck_i) rst_i |-> !cpu_req_o.stb)
    else $error("SPR strobe high during reset");

endmodule

bind dbg_or1k_spr_biu dbg_or1k_sva u_sva (
  .tck_i    (tck_i),
  .rst_i    (rst_i),
  .cpu_req_o(cpu_req_o),
  .cpu_ack_i(cpu_ack_i)
);

/* dbg_or1k_module.sv */
`timescale 1ns/1ps

module dbg_or1k_module
  import dbg_or1k_pkg::*;
#(
  parameter int CNT_W = 16
) (
  input  logic            tck_i,
  input  logic            rst_i,
  input  logic            tdi_i,
  input  logic            capture_dr_i,
  input  logic            shift_dr_i,
  input  logic            update_dr_i,
  input  logic [DR_W-1:0] data_register_i,
  input  logic            module_select_i,
  output logic            module_tdo_o,
  output logic            top_inhibit_o,
  output spr_req_t        cpu_req_o,
  input  logic [31:0]     cpu_rdata_i,
  input  logic            cpu_ack_i,
  input  logic            cpu_bp_i,
  output logic            cpu_stall_o,
  output logic            cpu_rst_o
);

  dp_ctrl_t    dp_ctrl;
  dp_stat_t    dp_stat;
  crc_ctrl_t   crc_ctrl;
  logic        module_cmd, burst_rd, burst_wr, ireg_sel, ireg_wr;
  logic        biu_strobe, biu_rdy, read_op, status_we;
  logic        crc_match, crc_serial, out_lsb;
  logic [31:0] addr, wdata, rdata;
  logic [1:0]  status;

  dbg_or1k_cmd_fsm u_fsm (
    .tck_i, .rst_i, .capture_dr_i, .shift_dr_i, .update_dr_i, .module_select_i,
    .start_bit_i (data_register_i[TOP_FLAG_BIT]),
    .module_cmd_i(module_cmd), .burst_rd_i(burst_rd), .burst_wr_i(burst_wr),
    .ireg_sel_i  (ireg_sel),   .ireg_wr_i (ireg_wr),  .stat_i    (dp_stat),
    .biu_rdy_i   (biu_rdy),    .ctrl_o    (dp_ctrl),  .crc_o     (crc_ctrl),
    .biu_strobe_o(biu_strobe), .status_we_o(status_we), .top_inhibit_o
  );

  dbg_or1k_datapath #(.CNT_W(CNT_W)) u_dp (
    .tck_i, .rst_i, .data_register_i, .tdi_i,
    .ctrl_i      (dp_ctrl),    .biu_rdata_i (rdata),    .status_i  (status),
    .crc_match_i (crc_match),  .crc_serial_i(crc_serial), .biu_rdy_i(biu_rdy),
    .stat_o      (dp_stat),    .module_cmd_o(module_cmd), .burst_rd_o(burst_rd),
    .burst_wr_o  (burst_wr),   .ireg_sel_o  (ireg_sel),   .ireg_wr_o (ireg_wr),
    .addr_o      (addr),       .wdata_o     (wdata),      .read_op_o (read_op),
    .out_lsb_o   (out_lsb),    .module_tdo_o
  );

  dbg_or1k_crc32 u_crc (
    .tck_i, .rst_i, .ctrl_i(crc_ctrl), .tdi_i, .out_lsb_i(out_lsb),
    .dr_word_i(data_register_i[TOP_FLAG_BIT -: 32]),  // Received CRC field
    .match_o  (crc_match), .serial_o(crc_serial)
  );

  dbg_or1k_spr_biu u_biu (
    .tck_i, .rst_i, .strobe_i(biu_strobe), .rd_i(read_op), .addr_i(addr),
    .wdata_i(wdata), .rdata_o(rdata), .rdy_o(biu_rdy), .cpu_req_o,
    .cpu_rdata_i, .cpu_ack_i
  );

  dbg_or1k_status_reg u_status (
    .tck_i, .rst_i, .we_i(status_we), .data_i(data_register_i[STAT_HI:STAT_LO]),
    .bp_i(cpu_bp_i), .status_o(status), .cpu_stall_o, .cpu_rst_o
  );

endmodule

/* dbg_or1k_cmd_fsm.sv */
`timescale 1ns/1ps

module dbg_or1k_cmd_fsm
  import dbg_or1k_pkg::*;
(
  input  logic      tck_i,
  input  logic      rst_i,
  input  logic      capture_dr_i,
  input  logic      shift_dr_i,
  input  logic      update_dr_i,
  input  logic      module_select_i,
  input  logic      start_bit_i,      // Data register MSB
  input  logic      module_cmd_i,
  input  logic      burst_rd_i,
  input  logic      burst_wr_i,
  input  logic      ireg_sel_i,
  input  logic      ireg_wr_i,
  input  dp_stat_t  stat_i,
  input  logic      biu_rdy_i,
  output dp_ctrl_t  ctrl_o,
  output crc_ctrl_t crc_o,
  output logic      biu_strobe_o,
  output logic      status_we_o,
  output logic      top_inhibit_o
);

  dbg_state_e state_q, state_d;
  logic       cmd_update;   // Update of a command addressed to this module

  assign cmd_update = module_select_i & module_cmd_i & update_dr_i;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) state_q <= ST_IDLE;
    else       state_q <= state_d;
  end

  ////////////////////
  // Next state and outputs
  ////////////////////

  always_comb begin
    state_d        = state_q;
    ctrl_o         = '0;
    ctrl_o.tdo_sel = TDO_DATA;   // Default shows the output register
    crc_o          = '0;
    biu_strobe_o   = 1'b0;
    status_we_o    = 1'b0;
    top_inhibit_o  = 1'b0;

    case (state_q)
      ST_IDLE: begin
        // Status readback, stays in Idle
        if (module_select_i && capture_dr_i) ctrl_o.out_load = 1'b1;
        if (module_select_i && shift_dr_i)   ctrl_o.out_shift = 1'b1;
        if (cmd_update) begin
          status_we_o = ireg_sel_i & ireg_wr_i;
          if (burst_rd_i)      state_d = ST_RBEGIN;
          else if (burst_wr_i) state_d = ST_WREADY;
        end
        if (cmd_update && (burst_rd_i || burst_wr_i)) begin
          ctrl_o.addr_load = 1'b1;    // Also latches the opcode
          ctrl_o.cnt_load  = 1'b1;
          ctrl_o.bit_clr   = 1'b1;
          crc_o.clr        = 1'b1;
        end
      end
      ST_RBEGIN: begin
        if (stat_i.word_zero) begin
          state_d = ST_IDLE;          // Empty burst
        end else begin
          biu_strobe_o    = 1'b1;     // First read goes out early
          ctrl_o.addr_inc = 1'b1;
          state_d         = ST_RREADY;
        end
      end
      ST_RREADY: begin
        if (module_select_i && capture_dr_i) state_d = ST_RSTATUS;
      end
      ST_RSTATUS: begin
        ctrl_o.tdo_sel = TDO_READY;   // Host polls for the ready bit
        top_inhibit_o  = 1'b1;
        if (update_dr_i) begin
          state_d = ST_IDLE;
        end else if (biu_rdy_i) begin
          state_d            = ST_RBURST;
          ctrl_o.out_load    = 1'b1;
          ctrl_o.out_src_biu = 1'b1;
          ctrl_o.bit_clr     = 1'b1;
          ctrl_o.cnt_dec     = 1'b1;
          if (!stat_i.word_last) begin
            biu_strobe_o    = 1'b1;   // Fetch the next word while this one shifts
            ctrl_o.addr_inc = 1'b1;
          end
        end
      end
      ST_RBURST: begin
        ctrl_o.out_shift = 1'b1;
        ctrl_o.bit_inc   = 1'b1;
        crc_o.en         = 1'b1;      // CRC over outgoing bits
        top_inhibit_o    = 1'b1;
        if (update_dr_i) begin
          state_d = ST_IDLE;
        end else if (stat_i.bit_max && stat_i.word_zero) begin
          state_d = ST_RCRC;
        end else if (stat_i.bit_max) begin
          ctrl_o.out_load    = 1'b1;  // Next word, back to back
          ctrl_o.out_src_biu = 1'b1;
          ctrl_o.bit_clr     = 1'b1;
          ctrl_o.cnt_dec     = 1'b1;
          if (!stat_i.word_last) begin
            biu_strobe_o    = 1'b1;
            ctrl_o.addr_inc = 1'b1;
          end
        end
      end
      ST_RCRC: begin
        ctrl_o.tdo_sel = TDO_CRC;
        crc_o.shift    = 1'b1;        // Runs until update, no count
        top_inhibit_o  = 1'b1;
        if (update_dr_i) state_d = ST_IDLE;
      end
      ST_WREADY: begin
        if (stat_i.word_zero)                     state_d = ST_IDLE;
        else if (module_select_i && capture_dr_i) state_d = ST_WWAIT;
      end
      ST_WWAIT: begin
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = ST_IDLE;
        end else if (module_select_i && start_bit_i) begin
          state_d        = ST_WBURST;
          ctrl_o.bit_inc = 1'b1;      // tdi already holds data bit 0
          ctrl_o.cnt_dec = 1'b1;
          crc_o.en       = 1'b1;
          crc_o.in_tdi   = 1'b1;
        end
      end
      ST_WBURST: begin
        ctrl_o.bit_inc = 1'b1;
        crc_o.en       = 1'b1;
        crc_o.in_tdi   = 1'b1;
        top_inhibit_o  = 1'b1;
        if (update_dr_i) begin
          state_d = ST_IDLE;
        end else if (stat_i.bit_max) begin
          biu_strobe_o    = 1'b1;     // Word complete with tdi as bit 31
          ctrl_o.addr_inc = 1'b1;
          ctrl_o.bit_clr  = 1'b1;
          ctrl_o.cnt_dec  = !stat_i.word_zero;
          if (stat_i.word_zero) state_d = ST_WCRC;
        end
      end
      ST_WCRC: begin
        ctrl_o.bit_inc = 1'b1;
        top_inhibit_o  = 1'b1;
        if (update_dr_i) begin
          state_d = ST_IDLE;
        end else if (stat_i.bit_32) begin
          state_d        = ST_WMATCH;
          ctrl_o.tdo_sel = TDO_MATCH; // Match bit goes out on this cycle
        end
      end
      ST_WMATCH: begin
        ctrl_o.tdo_sel = TDO_MATCH;
        top_inhibit_o  = 1'b1;
        if (update_dr_i) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

endmodule

/* dbg_or1k_datapath.sv */
`timescale 1ns/1ps

module dbg_or1k_datapath
  import dbg_or1k_pkg::*;
#(
  parameter int CNT_W = 16
) (
  input  logic            tck_i,
  input  logic            rst_i,
  input  logic [DR_W-1:0] data_register_i,
  input  logic            tdi_i,
  input  dp_ctrl_t        ctrl_i,
  input  logic [31:0]     biu_rdata_i,
  input  logic [1:0]      status_i,
  input  logic            crc_match_i,
  input  logic            crc_serial_i,
  input  logic            biu_rdy_i,
  output dp_stat_t        stat_o,
  output logic            module_cmd_o,
  output logic            burst_rd_o,
  output logic            burst_wr_o,
  output logic            ireg_sel_o,
  output logic            ireg_wr_o,
  output logic [31:0]     addr_o,
  output logic [31:0]     wdata_o,
  output logic            read_op_o,
  output logic            out_lsb_o,
  output logic            module_tdo_o
);

  logic [31:0]      addr_q;     // Next SPR address
  logic [CNT_W-1:0] word_cnt_q; // Words left in the burst
  logic [5:0]       bit_cnt_q;  // Bits of the current word
  logic [3:0]       op_q;       // Latched burst opcode
  logic [31:0]      out_q;      // Output shift register
  logic [3:0]       opc_in;

  ////////////////////
  // Command decode
  ////////////////////

  assign opc_in       = data_register_i[OPC_HI:OPC_LO];
  assign module_cmd_o = ~data_register_i[TOP_FLAG_BIT];
  assign burst_rd_o   = (opc_in == CMD_BREAD32);
  assign burst_wr_o   = (opc_in == CMD_BWRITE32);
  assign ireg_sel_o   = ((opc_in == CMD_IREG_SEL) || (opc_in == CMD_IREG_WR))
                        && (data_register_i[REGSEL_BIT] == INTREG_STATUS);
  assign ireg_wr_o    = (opc_in == CMD_IREG_WR);

  assign read_op_o = (op_q == CMD_BREAD32);
  assign wdata_o   = {tdi_i, data_register_i[TOP_FLAG_BIT -: 31]};  // tdi is bit 31
  assign addr_o    = addr_q;
  assign out_lsb_o = out_q[0];

  ////////////////////
  // Counters
  ////////////////////

  always_ff @(posedge tck_i) begin
    if (ctrl_i.addr_load)     addr_q <= data_register_i[ADDR_HI:ADDR_LO];
    else if (ctrl_i.addr_inc) addr_q <= addr_q + 32'd1;  // SPRs are word addressed
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      word_cnt_q <= '0;
      bit_cnt_q  <= '0;
      op_q       <= '0;
    end else begin
      if (ctrl_i.cnt_load)     word_cnt_q <= data_register_i[CNT_LO +: CNT_W];
      else if (ctrl_i.cnt_dec) word_cnt_q <= word_cnt_q - CNT_W'(1);
      if (ctrl_i.bit_clr)      bit_cnt_q <= '0;   // Clear wins over increment
      else if (ctrl_i.bit_inc) bit_cnt_q <= bit_cnt_q + 6'd1;
      if (ctrl_i.addr_load)    op_q <= opc_in;
    end
  end

  assign stat_o.word_zero = (word_cnt_q == '0);
  assign stat_o.word_last = (word_cnt_q == CNT_W'(1));
  assign stat_o.bit_max   = (bit_cnt_q == 6'd31);
  assign stat_o.bit_32    = (bit_cnt_q == 6'd32);

  ////////////////////
  // Output register and TDO
  ////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      out_q <= '0;
    end else if (ctrl_i.out_load) begin
      out_q <= ctrl_i.out_src_biu ? biu_rdata_i : {30'd0, status_i};
    end else if (ctrl_i.out_shift) begin
      out_q <= {1'b0, out_q[31:1]};  // LSB first
    end
  end

  always_comb begin
    case (ctrl_i.tdo_sel)
      TDO_READY: module_tdo_o = biu_rdy_i;
      TDO_DATA:  module_tdo_o = out_q[0];
      TDO_MATCH: module_tdo_o = crc_match_i;
      default:   module_tdo_o = crc_serial_i;
    endcase
  end

endmodule

/* dbg_or1k_spr_biu.sv */
`timescale 1ns/1ps

module dbg_or1k_spr_biu
  import dbg_or1k_pkg::*;
(
  input  logic        tck_i,
  input  logic        rst_i,
  input  logic        strobe_i,    // Start one access
  input  logic        rd_i,        // 1 read, 0 write
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata_o,
  output logic        rdy_o,
  output spr_req_t    cpu_req_o,
  input  logic [31:0] cpu_rdata_i,
  input  logic        cpu_ack_i
);

  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [31:0] rdata_q;
  logic        we_q;
  logic        stb_q;
  logic        rdy_q;

  // Request payload, held stable while stb is up
  always_ff @(posedge tck_i) begin
    if (strobe_i) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      we_q    <= ~rd_i;
    end
    if (stb_q && cpu_ack_i && !we_q) rdata_q <= cpu_rdata_i;
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      stb_q <= 1'b0;
      rdy_q <= 1'b1;     // Idle BIU is ready
    end else if (strobe_i) begin
      stb_q <= 1'b1;
      rdy_q <= 1'b0;
    end else if (stb_q && cpu_ack_i) begin
      stb_q <= 1'b0;     // Drops the cycle after ack
      rdy_q <= 1'b1;
    end
  end

  assign cpu_req_o = '{addr: addr_q, wdata: wdata_q, stb: stb_q, we: we_q};
  assign rdata_o   = rdata_q;
  assign rdy_o     = rdy_q;

endmodule

/* dbg_or1k_crc32.sv */
`timescale 1ns/1ps

module dbg_or1k_crc32
  import dbg_or1k_pkg::*;
(
  input  logic        tck_i,
  input  logic        rst_i,
  input  crc_ctrl_t   ctrl_i,
  input  logic        tdi_i,
  input  logic        out_lsb_i,
  input  logic [31:0] dr_word_i,   // Received CRC from the data register
  output logic        match_o,
  output logic        serial_o
);

  logic [31:0] crc_q;
  logic        fb;                  // Feedback bit

  assign fb = crc_q[0] ^ (ctrl_i.in_tdi ? tdi_i : out_lsb_i);

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= CRC_INIT;
    end else if (ctrl_i.clr) begin
      crc_q <= CRC_INIT;
    end else if (ctrl_i.en) begin
      crc_q <= {1'b0, crc_q[31:1]} ^ (fb ? CRC_POLY : 32'd0);
    end else if (ctrl_i.shift) begin
      crc_q <= {1'b0, crc_q[31:1]};   // Serial readout
    end
  end

  assign serial_o = crc_q[0];
  assign match_o  = (dr_word_i == crc_q);

endmodule

/* dbg_or1k_status_reg.sv */
`timescale 1ns/1ps

module dbg_or1k_status_reg (
  input  logic       tck_i,
  input  logic       rst_i,
  input  logic       we_i,
  input  logic [1:0] data_i,      // Bit 1 reset, bit 0 stall
  input  logic       bp_i,        // CPU breakpoint
  output logic [1:0] status_o,
  output logic       cpu_stall_o,
  output logic       cpu_rst_o
);

  logic [1:0] status_q;

  ////////////////////
  // Stall and reset bits
  ////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      status_q <= 2'b00;
    end else begin
      if (we_i) status_q <= data_i;       // Host write
      if (bp_i) status_q[0] <= 1'b1;      // Breakpoint stalls, wins over write
    end
  end

  assign status_o    = status_q;
  assign cpu_stall_o = status_q[0];
  assign cpu_rst_o   = status_q[1];

endmodule

/* dbg_or1k_pkg.sv */
package dbg_or1k_pkg;

  ////////////////////
  // Command word
  ////////////////////

  localparam int DR_W = 53;           // TAP data register width

  localparam logic [3:0] CMD_BWRITE32 = 4'd3;
  localparam logic [3:0] CMD_BREAD32  = 4'd7;
  localparam logic [3:0] CMD_IREG_WR  = 4'd9;
  localparam logic [3:0] CMD_IREG_SEL = 4'd13;

  // Field positions inside the data register
  localparam int TOP_FLAG_BIT = 52;   // 0 means the command is for this module
  localparam int OPC_HI       = 51;
  localparam int OPC_LO       = 48;
  localparam int ADDR_HI      = 47;
  localparam int ADDR_LO      = 16;
  localparam int CNT_LO       = 0;    // Count field starts here, width set by CNT_W
  localparam int REGSEL_BIT   = 47;
  localparam int STAT_HI      = 46;
  localparam int STAT_LO      = 45;

  localparam logic INTREG_STATUS = 1'b0;

  localparam logic [31:0] CRC_POLY = 32'hEDB88320;  // Reflected CRC-32
  localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

  ////////////////////
  // Types
  ////////////////////

  typedef enum logic [3:0] {
    ST_IDLE, ST_RBEGIN, ST_RREADY, ST_RSTATUS, ST_RBURST, ST_RCRC,
    ST_WREADY, ST_WWAIT, ST_WBURST, ST_WCRC, ST_WMATCH
  } dbg_state_e;

  typedef enum logic [1:0] {
    TDO_READY = 2'd0,   // BIU ready bit
    TDO_DATA  = 2'd1,   // Output shift register LSB
    TDO_MATCH = 2'd2,   // Write CRC compare result
    TDO_CRC   = 2'd3    // CRC register serial out
  } tdo_sel_e;

  typedef struct packed {
    logic     addr_load;
    logic     addr_inc;
    logic     cnt_load;
    logic     cnt_dec;
    logic     bit_clr;
    logic     bit_inc;
    logic     out_load;
    logic     out_shift;
    logic     out_src_biu;  // 1 loads BIU data, 0 loads status bits
    tdo_sel_e tdo_sel;
  } dp_ctrl_t;

  typedef struct packed {
    logic word_zero;
    logic word_last;   // Count is 1
    logic bit_max;     // Bit count is 31
    logic bit_32;
  } dp_stat_t;

  typedef struct packed {
    logic clr;
    logic en;
    logic in_tdi;      // 1 takes tdi, 0 takes output LSB
    logic shift;
  } crc_ctrl_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        stb;
    logic        we;
  } spr_req_t;

endpackage
